// File: src/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data path width in bits
`define LSU_XLEN 64

// number of XLEN-wide words in the data RAM
`define LSU_DEPTH 256

// word index width, log2 of LSU_DEPTH
`define LSU_IDX_W 8

`endif

// File: src/lsu_pkg.sv
`include "lsu_config.svh"

package lsu_pkg;

    // bit 3 marks a store, bits 1:0 give log2 of the access size
    typedef enum logic [3:0] {
        LB  = 4'h0,
        LH  = 4'h1,
        LW  = 4'h2,
        LD  = 4'h3,
        LBU = 4'h4,
        LHU = 4'h5,
        LWU = 4'h6,
        SB  = 4'h8,
        SH  = 4'h9,
        SW  = 4'ha,
        SD  = 4'hb
    } mem_op_e;

    typedef struct packed {
        mem_op_e               op;
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_XLEN-1:0] wdata;
    } lsu_req_t;

    typedef struct packed {
        logic [`LSU_IDX_W-1:0]  idx;
        logic                   wen;
        logic [`LSU_XLEN/8-1:0] wmask;
        logic [`LSU_XLEN-1:0]   wdata;
    } ram_acc_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0] rdata;
        logic                 fault;
        logic                 is_load;
    } lsu_rsp_t;

endpackage

// File: src/mem_access_decode.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module mem_access_decode (
    input  logic              req_valid,
    input  lsu_pkg::lsu_req_t req,
    output lsu_pkg::ram_acc_t acc,
    output logic              fault
);

    logic [1:0]             size_log2;
    logic                   is_store;
    logic [2:0]             offset;
    logic                   misaligned;
    logic [`LSU_XLEN/8-1:0] size_ones;

    assign offset = req.addr[2:0];

    // access size and direction from the opcode
    always_comb begin
        size_log2 = 2'd0;
        is_store  = 1'b0;
        case (req.op)
            lsu_pkg::LB, lsu_pkg::LBU: size_log2 = 2'd0;
            lsu_pkg::LH, lsu_pkg::LHU: size_log2 = 2'd1;
            lsu_pkg::LW, lsu_pkg::LWU: size_log2 = 2'd2;
            lsu_pkg::LD:               size_log2 = 2'd3;
            lsu_pkg::SB: begin
                size_log2 = 2'd0;
                is_store  = 1'b1;
            end
            lsu_pkg::SH: begin
                size_log2 = 2'd1;
                is_store  = 1'b1;
            end
            lsu_pkg::SW: begin
                size_log2 = 2'd2;
                is_store  = 1'b1;
            end
            lsu_pkg::SD: begin
                size_log2 = 2'd3;
                is_store  = 1'b1;
            end
            default: begin
                size_log2 = 2'd0;
                is_store  = 1'b0;
            end
        endcase
    end

    // natural alignment needs the offset bits below the size to be zero
    always_comb begin
        case (size_log2)
            2'd1:    misaligned = offset[0];
            2'd2:    misaligned = |offset[1:0];
            2'd3:    misaligned = |offset;
            default: misaligned = 1'b0;
        endcase
    end

    always_comb begin
        case (size_log2)
            2'd0:    size_ones = 8'h01;
            2'd1:    size_ones = 8'h03;
            2'd2:    size_ones = 8'h0f;
            default: size_ones = 8'hff;
        endcase
    end

    assign fault = req_valid & misaligned;

    always_comb begin
        acc.idx   = req.addr[`LSU_IDX_W+2:3];
        acc.wen   = req_valid & is_store & ~misaligned;
        acc.wmask = size_ones << offset;
        // bytes above the access size land outside the mask
        acc.wdata = req.wdata << {offset, 3'b000};
    end

endmodule

// File: src/data_ram.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module data_ram (
    input  logic                 clk,
    input  lsu_pkg::ram_acc_t    acc,
    output logic [`LSU_XLEN-1:0] rd_word
);

    logic [`LSU_XLEN-1:0]  mem [`LSU_DEPTH];
    logic [`LSU_IDX_W-1:0] rd_idx;

    // byte-lane writes under the mask
    always_ff @(posedge clk) begin
        for (int b = 0; b < `LSU_XLEN / 8; b++) begin
            if (acc.wen && acc.wmask[b]) begin
                mem[acc.idx][b*8 +: 8] <= acc.wdata[b*8 +: 8];
            end
        end
    end

    // read address is registered, data comes from the array afterwards
    always_ff @(posedge clk) begin
        rd_idx <= acc.idx;
    end

    // a write at the same edge is already in the array here
    assign rd_word = mem[rd_idx];

endmodule

// File: src/load_extract.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module load_extract (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  lsu_pkg::mem_op_e     op,
    input  logic [2:0]           offset,
    input  logic                 fault,
    input  logic [`LSU_XLEN-1:0] rd_word,
    output logic                 rsp_valid,
    output lsu_pkg::lsu_rsp_t    rsp
);

    logic                 valid_q;
    lsu_pkg::mem_op_e     op_q;
    logic [2:0]           offset_q;
    logic                 fault_q;
    logic [`LSU_XLEN-1:0] shifted;
    logic [`LSU_XLEN-1:0] load_val;
    logic                 is_load;

    // response stage, one cycle behind the request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q  <= 1'b0;
            op_q     <= lsu_pkg::LB;
            offset_q <= 3'd0;
            fault_q  <= 1'b0;
        end else begin
            valid_q  <= req_valid;
            op_q     <= op;
            offset_q <= offset;
            fault_q  <= fault;
        end
    end

    assign shifted = rd_word >> {offset_q, 3'b000};

    always_comb begin
        is_load  = 1'b1;
        load_val = '0;
        case (op_q)
            lsu_pkg::LB:  load_val = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
            lsu_pkg::LH:  load_val = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
            lsu_pkg::LW:  load_val = {{(`LSU_XLEN-32){shifted[31]}}, shifted[31:0]};
            lsu_pkg::LD:  load_val = shifted;
            lsu_pkg::LBU: load_val = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
            lsu_pkg::LHU: load_val = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
            lsu_pkg::LWU: load_val = {{(`LSU_XLEN-32){1'b0}}, shifted[31:0]};
            default: begin
                // stores and unused encodings
                is_load  = 1'b0;
                load_val = '0;
            end
        endcase
    end

    assign rsp_valid = valid_q;

    always_comb begin
        rsp.rdata   = (is_load && !fault_q) ? load_val : '0;
        rsp.fault   = fault_q;
        rsp.is_load = is_load;
    end

endmodule

// File: src/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_valid,
    input  lsu_pkg::lsu_req_t req,
    output logic              rsp_valid,
    output lsu_pkg::lsu_rsp_t rsp
);

    lsu_pkg::ram_acc_t    acc;
    logic                 fault;
    logic [`LSU_XLEN-1:0] rd_word;

    mem_access_decode mem_access_decode_inst (
        .req_valid (req_valid),
        .req       (req),
        .acc       (acc),
        .fault     (fault)
    );

    data_ram data_ram_inst (
        .clk     (clk),
        .acc     (acc),
        .rd_word (rd_word)
    );

    // lane info goes straight from the request into the response stage
    load_extract load_extract_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .op        (req.op),
        .offset    (req.addr[2:0]),
        .fault     (fault),
        .rd_word   (rd_word),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

// File: tb/lsu_checker.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_checker (
    input  logic              clk,
    input  logic              req_valid,
    input  lsu_pkg::lsu_req_t req,
    input  logic              rsp_valid,
    input  lsu_pkg::lsu_rsp_t rsp,
    output int                checked,
    output int                mismatches,
    output int                timing_errors
);

    logic [7:0]        model_mem [`LSU_DEPTH*8];
    lsu_pkg::lsu_rsp_t expect_q [$];
    int                checked_n = 0;
    int                mismatch_n = 0;
    int                timing_n = 0;

    assign checked       = checked_n;
    assign mismatches    = mismatch_n;
    assign timing_errors = timing_n;

    function automatic int access_bytes(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: return 1;
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
            lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic bit is_store_op(input lsu_pkg::mem_op_e op);
        return op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW, lsu_pkg::SD};
    endfunction

    function automatic bit is_signed_load(input lsu_pkg::mem_op_e op);
        return op inside {lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW};
    endfunction

    // applies one request to the byte model and returns the response it should get
    task model_request(input lsu_pkg::lsu_req_t r, output lsu_pkg::lsu_rsp_t exp);
        int          size;
        int          base;
        int          offset;
        logic [63:0] value;
        size   = access_bytes(r.op);
        offset = int'(r.addr[2:0]);
        // only the word index bits select the word and upper bits wrap
        base   = int'(r.addr[`LSU_IDX_W+2:3]) * 8;
        exp         = '0;
        exp.is_load = !is_store_op(r.op);
        exp.fault   = (offset % size) != 0;
        if (!exp.fault) begin
            if (is_store_op(r.op)) begin
                for (int k = 0; k < size; k++) begin
                    model_mem[base + offset + k] = r.wdata[8*k +: 8];
                end
            end else begin
                value = '0;
                for (int k = 0; k < size; k++) begin
                    value[8*k +: 8] = model_mem[base + offset + k];
                end
                if (is_signed_load(r.op) && value[8*size-1]) begin
                    for (int k = size; k < 8; k++) begin
                        value[8*k +: 8] = 8'hff;
                    end
                end
                exp.rdata = value;
            end
        end
    endtask

    // inputs and outputs both settle after the rising edge, so look at the falling one
    always @(negedge clk) begin : watch
        lsu_pkg::lsu_rsp_t expected;
        if (rsp_valid) begin
            if (expect_q.size() == 0) begin
                timing_n++;
                $display("%0t: response strobe without a request in the cycle before", $time);
            end else begin
                expected = expect_q.pop_front();
                checked_n++;
                if (rsp !== expected) begin
                    mismatch_n++;
                    $display("Mismatch at %0t: rdata %h exp %h, fault %b exp %b, is_load %b exp %b",
                             $time, rsp.rdata, expected.rdata, rsp.fault, expected.fault,
                             rsp.is_load, expected.is_load);
                end
            end
        end
        if (expect_q.size() != 0) begin
            timing_n++;
            $display("%0t: a request got no response strobe in the following cycle", $time);
            expect_q.delete();
        end
        if (req_valid) begin
            model_request(req, expected);
            expect_q.push_back(expected);
        end
    end

endmodule

// File: tb/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_tb;

    localparam int RAND_REQS       = 2000;
    localparam int WATCHDOG_CYCLES = (`LSU_DEPTH + RAND_REQS) * 2 + 100;

    logic              clk;
    logic              arst_n;
    logic              req_valid;
    lsu_pkg::lsu_req_t req;
    logic              rsp_valid;
    lsu_pkg::lsu_rsp_t rsp;
    int                checked;
    int                mismatches;
    int                timing_errors;
    logic [31:0]       lcg_state = 32'd73;
    lsu_pkg::mem_op_e  op_table [11] = '{lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW, lsu_pkg::LD,
                                         lsu_pkg::LBU, lsu_pkg::LHU, lsu_pkg::LWU,
                                         lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW, lsu_pkg::SD};

    lsu_top lsu_top_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    lsu_checker lsu_checker_inst (
        .clk           (clk),
        .req_valid     (req_valid),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .checked       (checked),
        .mismatches    (mismatches),
        .timing_errors (timing_errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // low LCG bits are weak, so draw from the upper ones
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[30:8]) % n;
    endfunction

    function automatic int size_of(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: return 1;
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
            lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW: return 4;
            default: return 8;
        endcase
    endfunction

    // random upper address bits exercise the wrap
    function automatic logic [63:0] word_addr(input int idx, input int offset);
        logic [63:0] a;
        a = {next_rand(), next_rand()};
        a[`LSU_IDX_W+2:3] = idx[`LSU_IDX_W-1:0];
        a[2:0] = offset[2:0];
        return a;
    endfunction

    task send(input lsu_pkg::mem_op_e op, input logic [63:0] addr, input logic [63:0] wdata);
        lsu_pkg::lsu_req_t r;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
    endtask

    task idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    task random_request();
        lsu_pkg::mem_op_e op;
        int               size;
        int               offset;
        op     = op_table[rand_below(11)];
        size   = size_of(op);
        offset = rand_below(8);
        if (rand_below(10) == 0) begin
            // knock an aligned offset one byte off since byte ops cannot misalign
            if (size > 1 && offset % size == 0) begin
                offset = offset + 1;
            end
        end else begin
            offset = offset - (offset % size);
        end
        send(op, word_addr(rand_below(64), offset), {next_rand(), next_rand()});
    endtask

    task directed_checks();
        send(lsu_pkg::SD, word_addr(5, 0), 64'h8877_6655_f4e3_d2c1);
        send(lsu_pkg::LD, word_addr(5, 0), '0);
        send(lsu_pkg::SB, word_addr(5, 3), 64'h1234_5678_9abc_dea5);
        send(lsu_pkg::LD, word_addr(5, 0), '0);
        // misaligned store leaves the word as it was
        send(lsu_pkg::SH, word_addr(5, 1), 64'hffff);
        send(lsu_pkg::LD, word_addr(5, 0), '0);
        for (int o = 0; o < 8; o++) begin
            send(lsu_pkg::LB, word_addr(5, o), '0);
            send(lsu_pkg::LBU, word_addr(5, o), '0);
            if (o % 2 == 0) begin
                send(lsu_pkg::LH, word_addr(5, o), '0);
                send(lsu_pkg::LHU, word_addr(5, o), '0);
            end
            if (o % 4 == 0) begin
                send(lsu_pkg::LW, word_addr(5, o), '0);
                send(lsu_pkg::LWU, word_addr(5, o), '0);
            end
        end
        send(lsu_pkg::LW, word_addr(5, 2), '0);
        idle(1);
    endtask

    initial begin
        int sent;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        idle(2);
        // every word gets written before anything reads it
        for (int i = 0; i < `LSU_DEPTH; i++) begin
            send(lsu_pkg::SD, word_addr(i, 0), {next_rand(), next_rand()});
        end
        directed_checks();
        sent = 0;
        while (sent < RAND_REQS) begin
            if (rand_below(10) < 7) begin
                random_request();
                sent++;
            end else begin
                idle(1);
            end
        end
        idle(4);
        if (checked == 0) begin
            $display("no responses were checked");
        end
        $display("closing report: %0d responses checked, %0d mismatches, %0d timing errors",
                 checked, mismatches, timing_errors);
        if (mismatches == 0 && timing_errors == 0 && checked > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+src
src/lsu_pkg.sv
src/mem_access_decode.sv
src/data_ram.sv
src/load_extract.sv
src/lsu_top.sv
tb/lsu_checker.sv
tb/lsu_tb.sv

// File: Makefile
TOP := lsu_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary -sv --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
